//--- branch_predictor.f
source/bp_cfg_pkg.sv
source/bp_types_pkg.sv
source/retire_filter.sv
source/plru_tree.sv
source/btb_array.sv
source/fetch_predict.sv
source/branch_predictor_top.sv
tests/branch_predictor_chk.sv
tests/branch_predictor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the branch predictor testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module branch_predictor_tb \
    -f branch_predictor.f \
    -o sim_branch_predictor; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_branch_predictor 2>&1)
run_status=$?
printf '%s\n' "$output"

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

//--- source/bp_cfg_pkg.sv
package bp_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address space
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int addr_w = 32;
  localparam logic [addr_w-1:0] inst_bytes = 4;  // Fall-through step of one instruction
  localparam int default_entries = 16;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Direction counter, one-hot
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [3:0] ctr_t;

  localparam ctr_t ctr_strong_nt = 4'b1000;
  localparam ctr_t ctr_weak_nt = 4'b0100;
  localparam ctr_t ctr_weak_t = 4'b0010;
  localparam ctr_t ctr_strong_t = 4'b0001;

  function automatic logic ctr_taken(input ctr_t ctr);
    return (ctr == ctr_weak_t) || (ctr == ctr_strong_t);  // Upper half of the counter
  endfunction

endpackage

//--- source/bp_types_pkg.sv
package bp_types_pkg;

  typedef struct packed {
    logic                            valid;
    logic [bp_cfg_pkg::addr_w-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic                            valid;
    logic                            retired;
    logic                            branch;
    logic                            pred_taken;  // Direction the fetch side used
    logic                            miss;        // Set when that direction was wrong
    logic [bp_cfg_pkg::addr_w-1:0] pc;
    logic [bp_cfg_pkg::addr_w-1:0] next_pc;
  } retire_t;

  typedef struct packed {
    logic                            valid;
    logic                            taken;       // True direction of the branch
    logic [bp_cfg_pkg::addr_w-1:0] pc;
    logic [bp_cfg_pkg::addr_w-1:0] target;
  } bp_update_t;

  typedef struct packed {
    logic                            hit;
    logic                            taken;
    logic [bp_cfg_pkg::addr_w-1:0] target;
  } lookup_t;

  typedef struct packed {
    logic                            valid;
    logic                            hit;
    logic                            taken;
    logic [bp_cfg_pkg::addr_w-1:0] next_pc;
  } prediction_t;

endpackage

//--- source/branch_predictor_top.sv
`timescale 1ns/10ps

module branch_predictor_top #(
  parameter int ENTRIES = bp_cfg_pkg::default_entries,
  localparam int IDX_W = $clog2(ENTRIES)
) (
  input  logic                      clk,
  input  logic                      rst,
  input  bp_types_pkg::fetch_req_t  fetch,
  input  bp_types_pkg::retire_t     retire,
  output bp_types_pkg::prediction_t pred
);

  bp_types_pkg::bp_update_t upd;
  bp_types_pkg::lookup_t    look;
  logic                     alloc;
  logic                     touch;
  logic [IDX_W-1:0]         touch_idx;
  logic [IDX_W-1:0]         victim;

  retire_filter filter0 (
    .clk    (clk),
    .rst    (rst),
    .retire (retire),
    .upd    (upd)
  );

  btb_array #(.ENTRIES(ENTRIES)) btb0 (
    .clk       (clk),
    .rst       (rst),
    .fetch     (fetch),
    .upd       (upd),
    .look      (look),
    .alloc     (alloc),
    .touch     (touch),
    .touch_idx (touch_idx),
    .victim    (victim)
  );

  plru_tree #(.ENTRIES(ENTRIES)) plru0 (
    .clk       (clk),
    .rst       (rst),
    .alloc     (alloc),
    .touch     (touch),
    .touch_idx (touch_idx),
    .victim    (victim)
  );

  fetch_predict predict0 (
    .clk   (clk),
    .rst   (rst),
    .fetch (fetch),
    .look  (look),
    .pred  (pred)
  );

endmodule

//--- source/btb_array.sv
`timescale 1ns/10ps

module btb_array #(
  parameter int ENTRIES = bp_cfg_pkg::default_entries,
  localparam int IDX_W = $clog2(ENTRIES)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  bp_types_pkg::fetch_req_t fetch,
  input  bp_types_pkg::bp_update_t upd,
  output bp_types_pkg::lookup_t    look,
  output logic                     alloc,
  output logic                     touch,
  output logic [IDX_W-1:0]         touch_idx,
  input  logic [IDX_W-1:0]         victim
);

  typedef struct packed {
    logic [bp_cfg_pkg::addr_w-1:0] pc;
    logic [bp_cfg_pkg::addr_w-1:0] target;
    bp_cfg_pkg::ctr_t              ctr;
  } entry_t;

  logic [ENTRIES-1:0] entry_valid;
  entry_t             entries [ENTRIES];

  logic               upd_hit;
  logic [IDX_W-1:0]   upd_idx;

  // One step toward the true direction, holding at either end
  function automatic bp_cfg_pkg::ctr_t ctr_step(input bp_cfg_pkg::ctr_t ctr,
                                                input logic taken);
    bp_cfg_pkg::ctr_t next;
    if (taken)
    begin
      case (ctr)
        bp_cfg_pkg::ctr_strong_nt: next = bp_cfg_pkg::ctr_weak_nt;
        bp_cfg_pkg::ctr_weak_nt:   next = bp_cfg_pkg::ctr_weak_t;
        bp_cfg_pkg::ctr_weak_t:    next = bp_cfg_pkg::ctr_strong_t;
        bp_cfg_pkg::ctr_strong_t:  next = bp_cfg_pkg::ctr_strong_t;
        default:                   next = bp_cfg_pkg::ctr_weak_t;  // Recover a bad state
      endcase
    end
    else
    begin
      case (ctr)
        bp_cfg_pkg::ctr_strong_nt: next = bp_cfg_pkg::ctr_strong_nt;
        bp_cfg_pkg::ctr_weak_nt:   next = bp_cfg_pkg::ctr_strong_nt;
        bp_cfg_pkg::ctr_weak_t:    next = bp_cfg_pkg::ctr_weak_nt;
        bp_cfg_pkg::ctr_strong_t:  next = bp_cfg_pkg::ctr_weak_t;
        default:                   next = bp_cfg_pkg::ctr_weak_nt;
      endcase
    end
    return next;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    look = '0;
    for (int i = 0; i < ENTRIES; i++)
    begin
      if (entry_valid[i] && (entries[i].pc == fetch.pc))
      begin
        look.hit    = 1'b1;
        look.taken  = bp_cfg_pkg::ctr_taken(entries[i].ctr);
        look.target = entries[i].target;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Retire match
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    upd_hit = 1'b0;
    upd_idx = '0;
    for (int i = 0; i < ENTRIES; i++)
    begin
      if (entry_valid[i] && (entries[i].pc == upd.pc))
      begin
        upd_hit = 1'b1;
        upd_idx = IDX_W'(i);  // Installs never duplicate a pc, so at most one match
      end
    end
  end

  assign touch     = upd.valid && upd_hit;
  assign alloc     = upd.valid && !upd_hit;
  assign touch_idx = upd_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table write
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
      entry_valid <= '0;
    else if (alloc)
      entry_valid[victim] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (touch)
    begin
      entries[upd_idx].target <= upd.target;
      entries[upd_idx].ctr    <= ctr_step(entries[upd_idx].ctr, upd.taken);
    end
    else if (alloc)
    begin
      entries[victim].pc     <= upd.pc;
      entries[victim].target <= upd.target;
      entries[victim].ctr    <= upd.taken ? bp_cfg_pkg::ctr_weak_t : bp_cfg_pkg::ctr_weak_nt;
    end
  end

endmodule

//--- source/fetch_predict.sv
`timescale 1ns/10ps

module fetch_predict (
  input  logic                      clk,
  input  logic                      rst,
  input  bp_types_pkg::fetch_req_t  fetch,
  input  bp_types_pkg::lookup_t     look,
  output bp_types_pkg::prediction_t pred
);

  logic                          redirect;
  logic [bp_cfg_pkg::addr_w-1:0] next_pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next address
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign redirect = look.hit && look.taken;

  always_comb
  begin
    if (redirect)
      next_pc = look.target;
    else
      next_pc = fetch.pc + bp_cfg_pkg::inst_bytes;  // Fall through
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Prediction register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
      pred.valid <= 1'b0;
    else
      pred.valid <= fetch.valid;
  end

  always_ff @(posedge clk)
  begin
    pred.hit     <= look.hit;
    pred.taken   <= redirect;  // Taken is never reported without a hit
    pred.next_pc <= next_pc;
  end

endmodule

//--- source/plru_tree.sv
`timescale 1ns/10ps

module plru_tree #(
  parameter int ENTRIES = bp_cfg_pkg::default_entries,
  localparam int IDX_W = $clog2(ENTRIES)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             alloc,
  input  logic             touch,
  input  logic [IDX_W-1:0] touch_idx,
  output logic [IDX_W-1:0] victim
);

  // Nodes sit in heap order with children 2n+1 and 2n+2. A zero bit points left
  logic [ENTRIES-2:0] tree_q;
  logic [ENTRIES-2:0] tree_d;
  logic [IDX_W-1:0]   path_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Victim walk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    int node;
    node = 0;
    victim = '0;
    for (int lvl = 0; lvl < IDX_W; lvl++)
    begin
      victim[IDX_W-1-lvl] = tree_q[node];  // Root decides the top index bit
      node = 2 * node + 1 + int'(tree_q[node]);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Path update
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Flipping the victim path is the same as pointing it away from the
  // victim, so alloc and touch share one rule on different paths
  assign path_idx = alloc ? victim : touch_idx;

  always_comb
  begin
    int node;
    node = 0;
    tree_d = tree_q;
    if (alloc || touch)
    begin
      for (int lvl = 0; lvl < IDX_W; lvl++)
      begin
        tree_d[node] = ~path_idx[IDX_W-1-lvl];
        node = 2 * node + 1 + int'(path_idx[IDX_W-1-lvl]);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      tree_q <= '0;
    else
      tree_q <= tree_d;
  end

endmodule

//--- source/retire_filter.sv
`timescale 1ns/10ps

module retire_filter (
  input  logic                   clk,
  input  logic                   rst,
  input  bp_types_pkg::retire_t  retire,
  output bp_types_pkg::bp_update_t upd
);

  logic train;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Qualification
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Only retired branches train the table. Squashed or non-branch
  // reports pass by without touching it
  assign train = retire.valid && retire.retired && retire.branch;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Update register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
      upd.valid <= 1'b0;
    else
      upd.valid <= train;
  end

  always_ff @(posedge clk)
  begin
    if (train)
    begin
      upd.taken  <= retire.pred_taken ^ retire.miss;  // A miss means the other way
      upd.pc     <= retire.pc;
      upd.target <= retire.next_pc;                   // Resolved address after the branch
    end
  end

endmodule

//--- tests/branch_predictor_chk.sv
`timescale 1ns/10ps

module branch_predictor_chk (
  input logic                      clk,
  input logic                      rst,
  input bp_types_pkg::fetch_req_t  fetch,
  input bp_types_pkg::prediction_t pred
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Prediction latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assert property (@(posedge clk) disable iff (rst) fetch.valid |=> pred.valid)
    else $error("pred.valid missing one cycle after fetch.valid");

  assert property (@(posedge clk) disable iff (rst) !fetch.valid |=> !pred.valid)
    else $error("pred.valid raised without a fetch one cycle before");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Prediction contents
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assert property (@(posedge clk) disable iff (rst) (pred.valid && pred.taken) |-> pred.hit)
    else $error("Taken prediction reported without a hit");

  assert property (@(posedge clk) disable iff (rst)
                   (pred.valid && !pred.taken) |->
                   (pred.next_pc == $past(fetch.pc) + bp_cfg_pkg::inst_bytes))
    else $error("Not-taken prediction does not fall through to pc plus 4");

endmodule

//--- tests/branch_predictor_tb.sv
`timescale 1ns/10ps

module branch_predictor_tb;

  typedef logic [bp_cfg_pkg::addr_w-1:0] addr_t;

  typedef struct packed {
    logic  is_fetch;
    logic  retired;
    logic  branch;
    logic  pred_taken;
    logic  miss;
    addr_t pc;
    addr_t next_pc;
    logic  exp_hit;
    logic  exp_taken;
    addr_t exp_next;
  } row_t;

  logic                      clk = 1'b0;
  logic                      rst = 1'b1;
  bp_types_pkg::fetch_req_t  fetch = '0;
  bp_types_pkg::retire_t     retire = '0;
  bp_types_pkg::prediction_t pred;

  row_t  rows [$];
  string row_names [$];
  addr_t fill_pcs [$];
  logic  table_ready = 1'b0;
  int    checks_run = 0;
  int    checks_failed = 0;

  branch_predictor_top #(.ENTRIES(16)) dut0 (
    .clk    (clk),
    .rst    (rst),
    .fetch  (fetch),
    .retire (retire),
    .pred   (pred)
  );

  bind branch_predictor_top branch_predictor_chk chk0 (
    .clk   (clk),
    .rst   (rst),
    .fetch (fetch),
    .pred  (pred)
  );

  always #10 clk = ~clk;  // 20 ns period

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table construction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic addr_t xorshift32(input addr_t x);
    addr_t s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic pick_fill_pcs();
    addr_t state;
    addr_t cand;
    logic  dup;
    state = 32'd99;
    while (fill_pcs.size() < 17)
    begin
      state = xorshift32(state);
      cand = 32'h4000_0000 | (state & 32'h00ff_fffc);  // Word aligned, clear of the fixed pcs
      dup = 1'b0;
      foreach (fill_pcs[k])
        if (fill_pcs[k] == cand)
          dup = 1'b1;
      if (!dup)
        fill_pcs.push_back(cand);
    end
  endtask

  task automatic queue_retire(input string name, input addr_t pc, input logic pred_taken,
                              input logic miss, input addr_t next_pc,
                              input logic branch, input logic retired);
    row_t r;
    r = '0;
    r.retired    = retired;
    r.branch     = branch;
    r.pred_taken = pred_taken;
    r.miss       = miss;
    r.pc         = pc;
    r.next_pc    = next_pc;
    rows.push_back(r);
    row_names.push_back(name);
  endtask

  task automatic expect_fetch(input string name, input addr_t pc, input logic hit,
                              input logic taken, input addr_t target);
    row_t r;
    r = '0;
    r.is_fetch  = 1'b1;
    r.pc        = pc;
    r.exp_hit   = hit;
    r.exp_taken = hit && taken;
    r.exp_next  = (hit && taken) ? target : pc + bp_cfg_pkg::inst_bytes;
    rows.push_back(r);
    row_names.push_back(name);
  endtask

  task automatic build_table();
    addr_t a;
    addr_t b;
    addr_t f;
    a = 32'h0000_1000;
    b = 32'h0000_1100;
    f = 32'h0000_1200;
    expect_fetch("empty_a", a, 1'b0, 1'b0, '0);
    expect_fetch("empty_b", b, 1'b0, 1'b0, '0);

    // Fills land in bit-reversed order and leave every tree bit at zero
    for (int k = 0; k < 16; k++)
      queue_retire($sformatf("fill_%0d", k), fill_pcs[k], 1'b0, 1'b1,
                   fill_pcs[k] + 32'h100, 1'b1, 1'b1);
    expect_fetch("fill_last_hits", fill_pcs[15], 1'b1, 1'b1, fill_pcs[15] + 32'h100);
    queue_retire("touch_first", fill_pcs[0], 1'b1, 1'b0, fill_pcs[0] + 32'h100, 1'b1, 1'b1);
    queue_retire("install_new", fill_pcs[16], 1'b0, 1'b1, fill_pcs[16] + 32'h100, 1'b1, 1'b1);
    expect_fetch("second_evicted", fill_pcs[1], 1'b0, 1'b0, '0);  // Walk after the touch ends at 8
    expect_fetch("first_kept", fill_pcs[0], 1'b1, 1'b1, fill_pcs[0] + 32'h100);
    expect_fetch("new_hits", fill_pcs[16], 1'b1, 1'b1, fill_pcs[16] + 32'h100);
    queue_retire("new_not_taken", fill_pcs[16], 1'b1, 1'b1, fill_pcs[16] + 32'd4, 1'b1, 1'b1);
    expect_fetch("new_was_weak", fill_pcs[16], 1'b1, 1'b0, '0);  // One step from weak taken

    queue_retire("install_taken", a, 1'b0, 1'b1, 32'h0000_1800, 1'b1, 1'b1);
    expect_fetch("taken_hit", a, 1'b1, 1'b1, 32'h0000_1800);
    queue_retire("install_not_taken", b, 1'b0, 1'b0, b + 32'd4, 1'b1, 1'b1);
    expect_fetch("not_taken_hit", b, 1'b1, 1'b0, b + 32'd4);
    queue_retire("flip_b_taken", b, 1'b0, 1'b1, 32'h0000_1180, 1'b1, 1'b1);
    expect_fetch("b_was_weak", b, 1'b1, 1'b1, 32'h0000_1180);

    queue_retire("train_t1", a, 1'b1, 1'b0, 32'h0000_1800, 1'b1, 1'b1);
    queue_retire("train_t2", a, 1'b1, 1'b0, 32'h0000_1800, 1'b1, 1'b1);
    expect_fetch("strong_taken", a, 1'b1, 1'b1, 32'h0000_1800);
    queue_retire("train_nt1", a, 1'b1, 1'b1, a + 32'd4, 1'b1, 1'b1);
    expect_fetch("still_taken", a, 1'b1, 1'b1, a + 32'd4);  // Target follows the fall-through
    queue_retire("train_nt2", a, 1'b1, 1'b1, a + 32'd4, 1'b1, 1'b1);
    expect_fetch("now_not_taken", a, 1'b1, 1'b0, '0);

    queue_retire("not_branch", f, 1'b0, 1'b1, 32'h0000_1300, 1'b0, 1'b1);
    queue_retire("not_retired", f, 1'b0, 1'b1, 32'h0000_1300, 1'b1, 1'b0);
    expect_fetch("filtered_miss", f, 1'b0, 1'b0, '0);

    queue_retire("new_target", a, 1'b0, 1'b1, 32'h0000_1a00, 1'b1, 1'b1);
    expect_fetch("target_moved", a, 1'b1, 1'b1, 32'h0000_1a00);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks and run
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_prediction(input string name, input row_t r);
    checks_run++;
    if (pred.valid !== 1'b1)
    begin
      checks_failed++;
      $display("%s: no prediction came back one cycle after the fetch", name);
    end
    else if (pred.hit !== r.exp_hit || pred.taken !== r.exp_taken ||
             pred.next_pc !== r.exp_next)
    begin
      checks_failed++;
      $display("CHECK FAILED %s: expected hit=%b taken=%b next=%h, actual hit=%b taken=%b next=%h",
               name, r.exp_hit, r.exp_taken, r.exp_next, pred.hit, pred.taken, pred.next_pc);
    end
    else
      $display("%s: ok", name);
  endtask

  initial
  begin
    row_t  r;
    string name;
    pick_fill_pcs();
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      name = row_names[i];
      @(posedge clk);
      if (r.is_fetch)
      begin
        fetch.valid <= 1'b1;
        fetch.pc    <= r.pc;
      end
      else
      begin
        retire.valid      <= 1'b1;
        retire.retired    <= r.retired;
        retire.branch     <= r.branch;
        retire.pred_taken <= r.pred_taken;
        retire.miss       <= r.miss;
        retire.pc         <= r.pc;
        retire.next_pc    <= r.next_pc;
      end
      @(posedge clk);
      fetch  <= '0;
      retire <= '0;
      if (r.is_fetch)
      begin
        @(negedge clk);  // Prediction registered at the edge before
        check_prediction(name, r);
      end
      else
      begin
        @(posedge clk);  // Second idle cycle lets the table write land
        $display("%s: retire applied", name);
      end
    end
    $display("Summary: %0d rows applied, %0d fetch checks, %0d failed",
             rows.size(), checks_run, checks_failed);
    if (checks_failed == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    int limit;
    wait (table_ready);
    limit = rows.size() * 4 + 100;
    @(negedge rst);
    repeat (limit) @(posedge clk);
    $display("Watchdog: the tests did not finish within %0d cycles after reset", limit);
    $display("Test failures found");
    $finish;
  end

endmodule
